//--- pkt_filter_pkg.sv
//************************************************
// Packet filter shared definitions
//************************************************

`default_nettype none

package pkt_filter_pkg;

	// Stream geometry
	localparam int AXIS_BYTES = 2;
	localparam int AXIS_USER_BITS = 1;
	localparam int AXIS_DATA_BITS = 8 * AXIS_BYTES;

	// tuser bit 0 flags an error seen by the source
	localparam int USER_ERR_BIT = 0;

	// Largest good packet in beats
	localparam int MAX_PKT_BEATS = 16;
	// Beat counter saturates at MAX_PKT_BEATS
	localparam int BEAT_CNT_BITS = $clog2(MAX_PKT_BEATS + 1);

	// 64 entries by default, well above the longest good packet
	localparam int FIFO_LOG2_DEPTH = 6;
	// One FIFO entry holds tlast, tdata, tuser and tkeep
	localparam int FIFO_ENTRY_BITS = 1 + AXIS_DATA_BITS + AXIS_USER_BITS + AXIS_BYTES;

	// Dropped packet counter width
	localparam int DROP_CNT_BITS = 16;

	// Checker state per packet
	typedef enum logic
	{
		CHK_GOOD = 1'b0, // Packet clean so far
		CHK_BAD  = 1'b1  // Packet already marked for drop
	} check_state_t;

endpackage

`default_nettype wire

//--- axis_if.sv
//************************************************
// AXI4-Stream interface
//************************************************

`timescale 1ns/1ps
`default_nettype none

interface axis_if;
	import pkt_filter_pkg::*;

	// Payload
	logic [AXIS_DATA_BITS-1:0] tdata;
	logic [AXIS_BYTES-1:0]     tkeep;
	logic [AXIS_USER_BITS-1:0] tuser;
	logic                      tlast;

	// Handshake
	logic tvalid;
	logic tready;

	// Driving side
	modport src
	(
		output tdata, tkeep, tuser, tlast, tvalid,
		input  tready
	);

	// Receiving side
	modport snk
	(
		input  tdata, tkeep, tuser, tlast, tvalid,
		output tready
	);

endinterface

`default_nettype wire

//--- axis_reg_slice.sv
//************************************************
// AXI4-Stream skid register slice
//************************************************

`timescale 1ns/1ps
`default_nettype none

module axis_reg_slice
(
	input  logic clk,
	input  logic sresetn,
	axis_if.snk  in,
	axis_if.src  out
);
	import pkt_filter_pkg::*;

	// Skid register catches the beat in flight when the output stalls
	logic [AXIS_DATA_BITS-1:0] skid_tdata;
	logic [AXIS_BYTES-1:0]     skid_tkeep;
	logic [AXIS_USER_BITS-1:0] skid_tuser;
	logic                      skid_tlast;
	logic                      skid_valid;
	logic                      skid_valid_nxt;

	// Registered ready towards the source
	logic ready_r;
	logic in_fire;
	// Main register free or emptying this cycle
	logic main_load;

	assign in.tready = ready_r;
	assign in_fire = in.tvalid && ready_r;
	assign main_load = !out.tvalid || out.tready;

	// Skid fills only while the main register is stuck
	always_comb
	begin
		skid_valid_nxt = skid_valid;
		if (main_load)
			skid_valid_nxt = 1'b0;
		else if (in_fire)
			skid_valid_nxt = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			out.tvalid <= 1'b0;
			skid_valid <= 1'b0;
			ready_r <= 1'b0;
		end
		else
		begin
			skid_valid <= skid_valid_nxt;
			// Accept again only while the skid is empty
			ready_r <= !skid_valid_nxt;
			if (main_load)
				out.tvalid <= skid_valid || in_fire;
		end
	end

	// Payload path, skid has priority over the input
	always_ff @(posedge clk)
	begin
		if (main_load)
		begin
			if (skid_valid)
			begin
				out.tdata <= skid_tdata;
				out.tkeep <= skid_tkeep;
				out.tuser <= skid_tuser;
				out.tlast <= skid_tlast;
			end
			else if (in_fire)
			begin
				out.tdata <= in.tdata;
				out.tkeep <= in.tkeep;
				out.tuser <= in.tuser;
				out.tlast <= in.tlast;
			end
		end
		else if (in_fire)
		begin
			skid_tdata <= in.tdata;
			skid_tkeep <= in.tkeep;
			skid_tuser <= in.tuser;
			skid_tlast <= in.tlast;
		end
	end

	// A presented beat stays until taken
	a_out_valid_hold: assert property (@(posedge clk) disable iff (!sresetn)
		out.tvalid && !out.tready |=> out.tvalid);

endmodule

`default_nettype wire

//--- pkt_check.sv
//************************************************
// Packet checker
//************************************************

`timescale 1ns/1ps
`default_nettype none

module pkt_check
(
	input  logic clk,
	input  logic sresetn,
	axis_if.snk  in,
	axis_if.src  out,
	output logic drop,
	output logic [pkt_filter_pkg::DROP_CNT_BITS-1:0] drop_count
);
	import pkt_filter_pkg::*;

	check_state_t state;
	// Beats already accepted in this packet, saturating
	logic [BEAT_CNT_BITS-1:0] beat_cnt;
	// Running modulo 256 sum of kept bytes
	logic [7:0] sum_r;
	logic [7:0] sum_nxt;
	logic [7:0] beat_sum;

	logic fire;
	logic err_beat;
	logic too_long;
	logic bad_sum;

	// Beats pass straight through, no latency
	assign out.tdata = in.tdata;
	assign out.tkeep = in.tkeep;
	assign out.tuser = in.tuser;
	assign out.tlast = in.tlast;
	assign out.tvalid = in.tvalid;
	assign in.tready = out.tready;

	assign fire = in.tvalid && in.tready;

	// Sum of the kept bytes in this beat
	always_comb
	begin
		beat_sum = 8'd0;
		for (int i = 0; i < AXIS_BYTES; i++)
		begin
			if (in.tkeep[i])
				beat_sum = beat_sum + in.tdata[8*i +: 8];
		end
	end

	assign sum_nxt = sum_r + beat_sum;

	// Drop reasons for the current beat
	assign err_beat = in.tuser[USER_ERR_BIT];
	// Beat MAX_PKT_BEATS+1 or beyond
	assign too_long = (beat_cnt == BEAT_CNT_BITS'(MAX_PKT_BEATS));
	// Checksum byte included, total must wrap to zero
	assign bad_sum = in.tlast && (sum_nxt != 8'd0);

	assign drop = in.tvalid && ((state == CHK_BAD) || err_beat || too_long || bad_sum);

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			state <= CHK_GOOD;
			beat_cnt <= '0;
			sum_r <= 8'd0;
			drop_count <= '0;
		end
		else if (fire)
		begin
			if (in.tlast)
			begin
				// Fresh tracking for the next packet
				state <= CHK_GOOD;
				beat_cnt <= '0;
				sum_r <= 8'd0;
				// One count per dropped packet, on its last beat
				if (drop)
					drop_count <= drop_count + 1'b1;
			end
			else
			begin
				if (drop)
					state <= CHK_BAD;
				if (!too_long)
					beat_cnt <= beat_cnt + 1'b1;
				sum_r <= sum_nxt;
			end
		end
	end

	// Drop only qualifies a real beat
	a_drop_needs_valid: assert property (@(posedge clk) disable iff (!sresetn)
		drop |-> in.tvalid);

endmodule

`default_nettype wire

//--- axis_packet_fifo.sv
//************************************************
// Packet FIFO with drop
//************************************************

`timescale 1ns/1ps
`default_nettype none

module axis_packet_fifo
#(
	parameter int LOG2_DEPTH = pkt_filter_pkg::FIFO_LOG2_DEPTH
)
(
	input  logic clk,
	input  logic sresetn,
	axis_if.snk  axis_i,
	input  logic axis_i_drop,
	axis_if.src  axis_o
);
	import pkt_filter_pkg::*;

	// Entry layout is tlast, tdata, tuser, tkeep
	logic [FIFO_ENTRY_BITS-1:0] mem [2**LOG2_DEPTH];

	// Extra top bit tells full from empty
	logic [LOG2_DEPTH:0] rd_ptr;
	logic [LOG2_DEPTH:0] wr_ptr;
	// Write pointer after the last complete packet
	logic [LOG2_DEPTH:0] committed_wr_ptr;

	logic full;
	// Packet marked bad on an earlier beat
	logic drop_r;
	logic in_fire;
	logic wr_en;
	logic rd_en;

	// Same address, different lap
	assign full = (rd_ptr[LOG2_DEPTH-1:0] == wr_ptr[LOG2_DEPTH-1:0]) &&
		(rd_ptr[LOG2_DEPTH] != wr_ptr[LOG2_DEPTH]);

	// A bad packet drains even when full
	assign axis_i.tready = !full || axis_i_drop;
	assign in_fire = axis_i.tvalid && axis_i.tready;
	assign wr_en = in_fire && !(drop_r || axis_i_drop);

	// Read committed data when the output register is free or emptying
	assign rd_en = (rd_ptr != committed_wr_ptr) && (!axis_o.tvalid || axis_o.tready);

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			committed_wr_ptr <= '0;
			drop_r <= 1'b0;
			axis_o.tvalid <= 1'b0;
		end
		else
		begin
			if (in_fire)
			begin
				// Sticky until the end of the packet
				if (axis_i.tlast)
					drop_r <= 1'b0;
				else if (axis_i_drop)
					drop_r <= 1'b1;

				if (!wr_en)
					wr_ptr <= committed_wr_ptr; // Rewind over the partial packet
				else
				begin
					wr_ptr <= wr_ptr + 1'b1;
					// Whole packet now visible to the reader
					if (axis_i.tlast)
						committed_wr_ptr <= wr_ptr + 1'b1;
				end
			end

			if (rd_en)
			begin
				axis_o.tvalid <= 1'b1;
				rd_ptr <= rd_ptr + 1'b1;
			end
			else if (axis_o.tready)
				axis_o.tvalid <= 1'b0;
		end
	end

	// Storage and output payload
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr[LOG2_DEPTH-1:0]] <=
				{axis_i.tlast, axis_i.tdata, axis_i.tuser, axis_i.tkeep};
		if (rd_en)
			{axis_o.tlast, axis_o.tdata, axis_o.tuser, axis_o.tkeep} <=
				mem[rd_ptr[LOG2_DEPTH-1:0]];
	end

	// No write into a full memory
	a_no_write_full: assert property (@(posedge clk) disable iff (!sresetn)
		wr_en |-> !full);

	// Reader stays behind the commit point
	a_rd_behind_commit: assert property (@(posedge clk) disable iff (!sresetn)
		(committed_wr_ptr - rd_ptr) <= (LOG2_DEPTH+1)'(2**LOG2_DEPTH));

endmodule

`default_nettype wire

//--- pkt_filter_top.sv
//************************************************
// Packet filter top level
//************************************************

`timescale 1ns/1ps
`default_nettype none

module pkt_filter_top
(
	input  logic clk,
	input  logic sresetn,

	// Input stream
	input  logic [pkt_filter_pkg::AXIS_DATA_BITS-1:0] s_tdata,
	input  logic [pkt_filter_pkg::AXIS_BYTES-1:0]     s_tkeep,
	input  logic [pkt_filter_pkg::AXIS_USER_BITS-1:0] s_tuser,
	input  logic                                      s_tlast,
	input  logic                                      s_tvalid,
	output logic                                      s_tready,

	// Filtered stream
	output logic [pkt_filter_pkg::AXIS_DATA_BITS-1:0] m_tdata,
	output logic [pkt_filter_pkg::AXIS_BYTES-1:0]     m_tkeep,
	output logic [pkt_filter_pkg::AXIS_USER_BITS-1:0] m_tuser,
	output logic                                      m_tlast,
	output logic                                      m_tvalid,
	input  logic                                      m_tready,

	output logic [pkt_filter_pkg::DROP_CNT_BITS-1:0]  drop_count
);
	import pkt_filter_pkg::*;

	axis_if a_in ();
	axis_if a_slice ();
	axis_if a_chk ();
	axis_if a_out ();

	// Drop flag of the beat on a_chk
	logic chk_drop;

	// Plain input ports onto the stream
	assign a_in.tdata = s_tdata;
	assign a_in.tkeep = s_tkeep;
	assign a_in.tuser = s_tuser;
	assign a_in.tlast = s_tlast;
	assign a_in.tvalid = s_tvalid;
	assign s_tready = a_in.tready;

	axis_reg_slice u_slice (.clk(clk), .sresetn(sresetn), .in(a_in), .out(a_slice));

	pkt_check u_check
	(
		.clk(clk),
		.sresetn(sresetn),
		.in(a_slice),
		.out(a_chk),
		.drop(chk_drop),
		.drop_count(drop_count)
	);

	axis_packet_fifo #(.LOG2_DEPTH(FIFO_LOG2_DEPTH)) u_fifo
	(
		.clk(clk),
		.sresetn(sresetn),
		.axis_i(a_chk),
		.axis_i_drop(chk_drop),
		.axis_o(a_out)
	);

	// Stream back onto plain output ports
	assign m_tdata = a_out.tdata;
	assign m_tkeep = a_out.tkeep;
	assign m_tuser = a_out.tuser;
	assign m_tlast = a_out.tlast;
	assign m_tvalid = a_out.tvalid;
	assign a_out.tready = m_tready;

endmodule

`default_nettype wire

//--- pkt_filter_tb.sv
//************************************************
// Packet filter testbench
//************************************************

`timescale 1ns/1ps
`default_nettype none

module pkt_filter_tb;
	import pkt_filter_pkg::*;

	// Packets per phase, the watchdog scales with them
	localparam int N_SWEEP = MAX_PKT_BEATS;
	localparam int N_HOLD = 8;
	localparam int N_RAND = 60;
	localparam int WD_CYCLES = 60 * (N_SWEEP + N_HOLD + N_RAND) + 1000;
	// Packet kinds
	localparam int K_GOOD = 0;
	localparam int K_BADSUM = 1;
	localparam int K_ERR = 2;
	localparam int K_LONG = 3;

	typedef logic [7:0] byte_q_t [$];

	logic clk;
	logic sresetn;
	logic [AXIS_DATA_BITS-1:0] s_tdata;
	logic [AXIS_BYTES-1:0]     s_tkeep;
	logic [AXIS_USER_BITS-1:0] s_tuser;
	logic s_tlast;
	logic s_tvalid;
	logic s_tready;
	logic [AXIS_DATA_BITS-1:0] m_tdata;
	logic [AXIS_BYTES-1:0]     m_tkeep;
	logic [AXIS_USER_BITS-1:0] m_tuser;
	logic m_tlast;
	logic m_tvalid;
	logic m_tready;
	logic [DROP_CNT_BITS-1:0] drop_count;

	// Beats still due at the output, as {tlast, tuser, tkeep, tdata}
	logic [AXIS_DATA_BITS+AXIS_BYTES+AXIS_USER_BITS:0] exp_q [$];
	logic [AXIS_DATA_BITS+AXIS_BYTES+AXIS_USER_BITS:0] want;
	int errors;
	int exp_drops;
	int seed;
	int kind;
	int beats;
	bit hold_ready;
	bit saw_full;

	pkt_filter_top UUT
	(
		.clk(clk), .sresetn(sresetn),
		.s_tdata(s_tdata), .s_tkeep(s_tkeep), .s_tuser(s_tuser),
		.s_tlast(s_tlast), .s_tvalid(s_tvalid), .s_tready(s_tready),
		.m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tuser(m_tuser),
		.m_tlast(m_tlast), .m_tvalid(m_tvalid), .m_tready(m_tready),
		.drop_count(drop_count)
	);

	always #10 clk = ~clk;

	// Sink ready, random unless held low to fill the FIFO
	always @(posedge clk)
	begin
		if (!sresetn || hold_ready)
			m_tready <= 1'b0;
		else
			m_tready <= ($urandom % 4) != 0;
	end

	// Expected fate of a packet: error bit, length, then checksum
	function automatic bit pkt_keep(input byte_q_t bytes, input bit err);
		logic [7:0] sum;
		int nbeats;
		sum = 8'd0;
		nbeats = (bytes.size() + AXIS_BYTES - 1) / AXIS_BYTES;
		foreach (bytes[i])
			sum = sum + bytes[i];
		return !err && (nbeats <= MAX_PKT_BEATS) && (sum == 8'd0);
	endfunction

	// One beat, held until the slice takes it
	task automatic send_beat(input logic [AXIS_DATA_BITS-1:0] data,
		input logic [AXIS_BYTES-1:0] keep, input logic err, input logic last);
		int stall;
		stall = 0;
		// Idle cycle now and then
		if ($urandom % 4 == 0)
		begin
			s_tvalid <= 1'b0;
			@(posedge clk);
		end
		s_tdata <= data;
		s_tkeep <= keep;
		s_tuser <= AXIS_USER_BITS'(err);
		s_tlast <= last;
		s_tvalid <= 1'b1;
		@(posedge clk);
		while (!s_tready)
		begin
			stall++;
			// A long stall under held ready means the FIFO backed up
			if (hold_ready && stall == 30)
			begin
				saw_full <= 1'b1;
				hold_ready <= 1'b0;
			end
			@(posedge clk);
		end
	endtask

	// Builds a packet of the given kind, records its fate, sends it
	task automatic send_packet(input int pkind, input int nbeats);
		byte_q_t bytes;
		logic [7:0] sum;
		logic [AXIS_DATA_BITS-1:0] data;
		logic [AXIS_BYTES-1:0] keep;
		int nbytes;
		int err_beat;
		int idx;
		bit keep_pkt;
		// Last beat carries one or two bytes
		nbytes = AXIS_BYTES * nbeats - int'($urandom % 2);
		sum = 8'd0;
		for (int i = 0; i < nbytes - 1; i++)
		begin
			bytes.push_back(8'($urandom));
			sum = sum + bytes[i];
		end
		// Checksum byte, off by 1 to 255 for a corrupted packet
		if (pkind == K_BADSUM)
			bytes.push_back(8'(8'd1 + ($urandom % 255) - sum));
		else
			bytes.push_back(-sum);
		err_beat = (pkind == K_ERR) ? int'($urandom % nbeats) : -1;
		keep_pkt = pkt_keep(bytes, pkind == K_ERR);
		if (!keep_pkt)
			exp_drops++;
		idx = 0;
		for (int b = 0; b < nbeats; b++)
		begin
			for (int i = 0; i < AXIS_BYTES; i++)
			begin
				keep[i] = idx < nbytes;
				// Junk in unkept lanes, the checksum must ignore it
				data[8*i +: 8] = keep[i] ? bytes[idx] : 8'($urandom);
				idx++;
			end
			if (keep_pkt)
				exp_q.push_back({b == nbeats - 1, AXIS_USER_BITS'(b == err_beat), keep, data});
			send_beat(data, keep, b == err_beat, b == nbeats - 1);
		end
	endtask

	// Scoreboard on every output transfer
	always @(posedge clk)
	begin
		if (sresetn && m_tvalid && m_tready)
		begin
			assert (exp_q.size() != 0)
			else
			begin
				$display("Output beat arrived while no beat was expected");
				errors++;
			end
			if (exp_q.size() != 0)
			begin
				want = exp_q.pop_front();
				assert (m_tdata == want[AXIS_DATA_BITS-1:0])
				else
				begin
					$display("FAIL m_tdata got %h expected %h", m_tdata,
						want[AXIS_DATA_BITS-1:0]);
					errors++;
				end
				assert (m_tkeep == want[AXIS_DATA_BITS +: AXIS_BYTES])
				else
				begin
					$display("FAIL m_tkeep got %h expected %h", m_tkeep,
						want[AXIS_DATA_BITS +: AXIS_BYTES]);
					errors++;
				end
				assert (m_tuser == want[AXIS_DATA_BITS+AXIS_BYTES +: AXIS_USER_BITS])
				else
				begin
					$display("FAIL m_tuser got %h expected %h", m_tuser,
						want[AXIS_DATA_BITS+AXIS_BYTES +: AXIS_USER_BITS]);
					errors++;
				end
				assert (m_tlast == want[AXIS_DATA_BITS+AXIS_BYTES+AXIS_USER_BITS])
				else
				begin
					$display("FAIL m_tlast got %h expected %h", m_tlast,
						want[AXIS_DATA_BITS+AXIS_BYTES+AXIS_USER_BITS]);
					errors++;
				end
			end
		end
	end

	// Watchdog
	initial
	begin
		#(WD_CYCLES * 20);
		$display("Timeout, the run did not finish within %0d cycles", WD_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		seed = $urandom(32'h9082);
		errors = 0;
		exp_drops = 0;
		hold_ready = 1'b0;
		saw_full = 1'b0;
		clk = 1'b0;
		sresetn = 1'b0;
		s_tdata = '0;
		s_tkeep = '0;
		s_tuser = '0;
		s_tlast = 1'b0;
		s_tvalid = 1'b0;
		m_tready = 1'b0;
		repeat (8) @(posedge clk);
		sresetn <= 1'b1;
		// Quiet output straight out of reset
		assert (m_tvalid == 1'b0)
		else
		begin
			$display("FAIL m_tvalid got %h expected 0 after reset", m_tvalid);
			errors++;
		end
		assert (drop_count == '0)
		else
		begin
			$display("FAIL drop_count got %h expected 0 after reset", drop_count);
			errors++;
		end

		// Every good length once
		for (int len = 1; len <= MAX_PKT_BEATS; len++)
			send_packet(K_GOOD, len);

		// Stalled sink backs the stream up to s_tready
		hold_ready <= 1'b1;
		for (int n = 0; n < N_HOLD; n++)
			send_packet(K_GOOD, 12);
		hold_ready <= 1'b0;
		assert (saw_full)
		else
		begin
			$display("s_tready never fell while m_tready was held low");
			errors++;
		end

		// Mixed good and bad traffic
		for (int n = 0; n < N_RAND; n++)
		begin
			kind = int'($urandom % 4);
			if (kind == K_LONG)
				beats = MAX_PKT_BEATS + 1 + int'($urandom % 4);
			else
				beats = 1 + int'($urandom % 20);
			send_packet(kind, beats);
		end
		s_tvalid <= 1'b0;

		// Drain, then let trailing drops settle
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (20) @(posedge clk);
		assert (drop_count == DROP_CNT_BITS'(exp_drops))
		else
		begin
			$display("FAIL drop_count got %h expected %h", drop_count,
				DROP_CNT_BITS'(exp_drops));
			errors++;
		end

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
pkt_filter_pkg.sv
axis_if.sv
axis_reg_slice.sv
pkt_check.sv
axis_packet_fifo.sv
pkt_filter_top.sv
pkt_filter_tb.sv
